/* files.f */
hdl/dcache_pkg.sv
hdl/dcache_array_if.sv
hdl/dcache_store.sv
hdl/dcache_match.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
test/tb_clock.sv
test/apb_mem_model.sv
test/tb_dcache.sv

/* hdl/dcache_array_if.sv */
`timescale 1ns/1ns

interface dcache_array_if;

  dcache_pkg::index_t rd_index;                                  // set to read, result next cycle
  dcache_pkg::index_t wr_index;                                  // set to write
  logic [dcache_pkg::NUM_WAYS-1:0] tag_we;                       // whole entry per way
  dcache_pkg::tag_entry_t [dcache_pkg::NUM_WAYS-1:0] tag_wdata;
  logic [dcache_pkg::NUM_WAYS-1:0] data_we;                      // at most one way
  dcache_pkg::strb_t byte_en;                                    // lanes of wdata to store
  dcache_pkg::word_t wdata;
  dcache_pkg::tag_entry_t [dcache_pkg::NUM_WAYS-1:0] rd_tags;    // registered read
  dcache_pkg::word_t [dcache_pkg::NUM_WAYS-1:0] rd_data;         // registered read

  modport ctrl (
    output rd_index,
    output wr_index,
    output tag_we,
    output tag_wdata,
    output data_we,
    output byte_en,
    output wdata,
    input  rd_data
  );

  modport store (
    input  rd_index,
    input  wr_index,
    input  tag_we,
    input  tag_wdata,
    input  data_we,
    input  byte_en,
    input  wdata,
    output rd_tags,
    output rd_data
  );

  modport match (
    input  rd_tags
  );

endinterface

/* hdl/dcache_ctrl.sv */
`timescale 1ns/1ns

module dcache_ctrl (
  input  logic                                       CLK,
  input  logic                                       resetn,
  input  logic                                       s_psel,
  input  logic                                       s_penable,
  input  logic                                       s_pwrite,
  input  dcache_pkg::addr_t                          s_paddr,
  input  dcache_pkg::word_t                          s_pwdata,
  input  dcache_pkg::strb_t                          s_pstrb,
  output dcache_pkg::word_t                          s_prdata,
  output logic                                       s_pready,
  output logic                                       m_psel,
  output logic                                       m_penable,
  output logic                                       m_pwrite,
  output dcache_pkg::addr_t                          m_paddr,
  output dcache_pkg::word_t                          m_pwdata,
  output dcache_pkg::strb_t                          m_pstrb,
  input  dcache_pkg::word_t                          m_prdata,
  input  logic                                       m_pready,
  dcache_array_if.ctrl                               arr,
  input  logic                                       hit,
  input  dcache_pkg::way_t                           hit_way,
  input  dcache_pkg::way_t                           victim_way,
  input  dcache_pkg::tag_entry_t [dcache_pkg::NUM_WAYS-1:0] new_tags,
  output dcache_pkg::tag_t                           req_tag,
  output logic                                       fill_sel
);

  dcache_pkg::ctrl_state_t state, next_state;
  dcache_pkg::index_t      sweep_cnt;   // set being cleared
  dcache_pkg::addr_t       req_addr;    // registered cpu request
  logic                    req_write;
  dcache_pkg::word_t       req_wdata;
  dcache_pkg::strb_t       req_strb;
  dcache_pkg::word_t       fill_data;   // word fetched from memory
  dcache_pkg::index_t      req_index;
  logic                    accept;      // cpu setup cycle seen

  assign req_index = req_addr[dcache_pkg::TAG_LSB-1:dcache_pkg::OFFSET_W];
  assign req_tag   = req_addr[dcache_pkg::ADDR_W-1:dcache_pkg::TAG_LSB];
  assign accept    = (state == dcache_pkg::IDLE) && s_psel && !s_penable;
  assign fill_sel  = (state == dcache_pkg::FILL_WRITE);

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      state     <= dcache_pkg::SWEEP;
      sweep_cnt <= '0;
    end else begin
      state <= next_state;
      if (state == dcache_pkg::SWEEP) begin
        sweep_cnt <= sweep_cnt + 1'b1;  // one set per cycle
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (accept) begin
      req_addr  <= s_paddr;
      req_write <= s_pwrite;
      req_wdata <= s_pwdata;
      req_strb  <= s_pstrb;
    end
    if ((state == dcache_pkg::FILL_ACCESS) && m_pready) begin
      fill_data <= m_prdata;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      dcache_pkg::SWEEP:        if (sweep_cnt == '1) next_state = dcache_pkg::IDLE;  // last set
      dcache_pkg::IDLE:         if (accept) next_state = dcache_pkg::LOOKUP;
      dcache_pkg::LOOKUP: begin
        if (req_write) begin
          next_state = dcache_pkg::STORE_SETUP;  // write-through, hit or miss
        end else if (hit) begin
          next_state = dcache_pkg::IDLE;
        end else begin
          next_state = dcache_pkg::FILL_SETUP;
        end
      end
      dcache_pkg::FILL_SETUP:   next_state = dcache_pkg::FILL_ACCESS;
      dcache_pkg::FILL_ACCESS:  if (m_pready) next_state = dcache_pkg::FILL_WRITE;
      dcache_pkg::FILL_WRITE:   next_state = dcache_pkg::IDLE;
      dcache_pkg::STORE_SETUP:  next_state = dcache_pkg::STORE_ACCESS;
      dcache_pkg::STORE_ACCESS: if (m_pready) next_state = dcache_pkg::IDLE;
      default:                  next_state = dcache_pkg::SWEEP;
    endcase
  end

  // apb master phases
  always_comb begin
    m_psel    = 1'b0;
    m_penable = 1'b0;
    m_pwrite  = 1'b0;
    case (state)
      dcache_pkg::FILL_SETUP:  m_psel = 1'b1;
      dcache_pkg::FILL_ACCESS: begin
        m_psel    = 1'b1;
        m_penable = 1'b1;
      end
      dcache_pkg::STORE_SETUP: begin
        m_psel   = 1'b1;
        m_pwrite = 1'b1;
      end
      dcache_pkg::STORE_ACCESS: begin
        m_psel    = 1'b1;
        m_penable = 1'b1;
        m_pwrite  = 1'b1;
      end
      default: m_psel = 1'b0;
    endcase
  end

  assign m_paddr  = {req_addr[dcache_pkg::ADDR_W-1:dcache_pkg::OFFSET_W],
                     {dcache_pkg::OFFSET_W{1'b0}}};                       // word aligned
  assign m_pwdata = req_wdata;
  assign m_pstrb  = req_write ? req_strb : '0;                            // no strobes on reads

  // apb slave completion
  always_comb begin
    case (state)
      dcache_pkg::LOOKUP:       s_pready = hit && !req_write;  // read hit
      dcache_pkg::FILL_WRITE:   s_pready = 1'b1;
      dcache_pkg::STORE_ACCESS: s_pready = m_pready;           // ends with memory write
      default:                  s_pready = 1'b0;
    endcase
  end

  assign s_prdata = fill_sel ? fill_data : arr.rd_data[hit_way];

  // array ports
  always_comb begin
    arr.rd_index  = (state == dcache_pkg::IDLE) ?
                    s_paddr[dcache_pkg::TAG_LSB-1:dcache_pkg::OFFSET_W] : req_index;
    arr.wr_index  = (state == dcache_pkg::SWEEP) ? sweep_cnt : req_index;
    arr.tag_we    = '0;
    arr.tag_wdata = new_tags;
    arr.data_we   = '0;
    arr.byte_en   = req_strb;
    arr.wdata     = req_wdata;
    case (state)
      dcache_pkg::SWEEP: begin
        arr.tag_we    = '1;
        arr.tag_wdata = '0;  // valid cleared in all ways
      end
      dcache_pkg::LOOKUP: begin
        if (hit) begin
          arr.tag_we = '1;  // ages of whole set
          arr.data_we[hit_way] = req_write;
        end
      end
      dcache_pkg::FILL_WRITE: begin
        arr.tag_we              = '1;
        arr.data_we[victim_way] = 1'b1;
        arr.byte_en             = '1;  // full word refill
        arr.wdata               = fill_data;
      end
      default: arr.tag_we = '0;
    endcase
  end

  assert property (@(posedge CLK) (state == dcache_pkg::SWEEP) |-> !m_psel)
    else $error("memory bus selected during invalidate sweep");

  // completion only while the cpu holds an access phase
  assert property (@(posedge CLK) disable iff (!resetn) s_pready |-> (s_psel && s_penable))
    else $error("s_pready outside cpu access phase");

endmodule

/* hdl/dcache_match.sv */
`timescale 1ns/1ns

module dcache_match (
  dcache_array_if.match                              arr,
  input  dcache_pkg::tag_t                           req_tag,
  input  logic                                       fill_sel,
  output logic                                       hit,
  output dcache_pkg::way_t                           hit_way,
  output dcache_pkg::way_t                           victim_way,
  output dcache_pkg::tag_entry_t [dcache_pkg::NUM_WAYS-1:0] new_tags
);

  logic [dcache_pkg::NUM_WAYS-1:0]              way_valid;
  logic [dcache_pkg::NUM_WAYS-1:0]              way_hit;
  dcache_pkg::age_t [dcache_pkg::NUM_WAYS-1:0]  eff_age;  // invalid ways read as lru
  dcache_pkg::way_t                             sel_way;  // way being touched
  dcache_pkg::age_t                             sel_age;

  // per-way decode of the tag entries
  always_comb begin
    for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
      way_valid[w] = arr.rd_tags[w][dcache_pkg::TE_VALID];
      way_hit[w]   = way_valid[w] &&
                     (arr.rd_tags[w][dcache_pkg::TE_AGE_LSB-1:dcache_pkg::TE_TAG_LSB] == req_tag);
      eff_age[w]   = way_valid[w] ? arr.rd_tags[w][dcache_pkg::TE_VALID-1:dcache_pkg::TE_AGE_LSB]
                                  : dcache_pkg::AGE_LRU;
    end
  end

  // hit way encoder
  always_comb begin
    hit     = |way_hit;
    hit_way = '0;
    for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
      if (way_hit[w]) begin
        hit_way = dcache_pkg::way_t'(w);
      end
    end
  end

  // victim: lowest invalid way, else the oldest one
  always_comb begin
    logic found_free;
    found_free = 1'b0;
    victim_way = '0;
    for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
      if (!found_free && !way_valid[w]) begin
        victim_way = dcache_pkg::way_t'(w);
        found_free = 1'b1;
      end
    end
    if (!found_free) begin
      for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
        if (eff_age[w] == dcache_pkg::AGE_LRU) begin
          victim_way = dcache_pkg::way_t'(w);  // ages form a permutation, one match
        end
      end
    end
  end

  assign sel_way = fill_sel ? victim_way : hit_way;
  assign sel_age = eff_age[sel_way];

  // age update, plus new tag and valid on refill
  always_comb begin
    new_tags = arr.rd_tags;
    for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
      if (dcache_pkg::way_t'(w) == sel_way) begin
        new_tags[w][dcache_pkg::TE_VALID-1:dcache_pkg::TE_AGE_LSB] = dcache_pkg::AGE_MRU;
      end else if (way_valid[w] && (eff_age[w] < sel_age)) begin
        new_tags[w][dcache_pkg::TE_VALID-1:dcache_pkg::TE_AGE_LSB] = eff_age[w] + 1'b1;  // ages by one
      end
    end
    if (fill_sel) begin
      new_tags[victim_way][dcache_pkg::TE_VALID] = 1'b1;
      new_tags[victim_way][dcache_pkg::TE_AGE_LSB-1:dcache_pkg::TE_TAG_LSB] = req_tag;
    end
  end

  // fills only on miss, so a set never holds one tag twice
  always_comb begin
    if (!$isunknown(way_hit)) begin
      assert final ($onehot0(way_hit))
        else $error("tag %h hits in more than one way: %b", req_tag, way_hit);
    end
  end

endmodule

/* hdl/dcache_pkg.sv */
package dcache_pkg;

  localparam int NUM_WAYS = 4;    // 4-way set associative
  localparam int NUM_SETS = 256;  // one word per line
  localparam int INDEX_W  = 8;    // addr[9:2]
  localparam int TAG_W    = 10;   // addr[19:10]
  localparam int AGE_W    = 2;    // lru age per way
  localparam int ADDR_W   = 20;   // 1 MB byte space
  localparam int DATA_W   = 32;
  localparam int STRB_W   = 4;    // one strobe per byte lane

  localparam int OFFSET_W = 2;                   // byte offset in word
  localparam int TAG_LSB  = OFFSET_W + INDEX_W;  // first tag bit of addr

  // tag entry layout, {valid, age, tag}
  localparam int TE_TAG_LSB = 0;
  localparam int TE_AGE_LSB = TAG_W;          // bits 11:10
  localparam int TE_VALID   = TAG_W + AGE_W;  // bit 12
  localparam int TE_W       = TE_VALID + 1;   // 13 bits

  typedef logic [ADDR_W-1:0]           addr_t;
  typedef logic [INDEX_W-1:0]          index_t;
  typedef logic [TAG_W-1:0]            tag_t;
  typedef logic [AGE_W-1:0]            age_t;
  typedef logic [DATA_W-1:0]           word_t;
  typedef logic [STRB_W-1:0]           strb_t;
  typedef logic [$clog2(NUM_WAYS)-1:0] way_t;
  typedef logic [TE_W-1:0]             tag_entry_t;

  localparam age_t AGE_MRU = '0;  // just used
  localparam age_t AGE_LRU = '1;  // next victim, also age of invalid way

  typedef enum logic [2:0] {
    SWEEP,         // clearing valid bits after reset
    IDLE,          // waiting for cpu setup cycle
    LOOKUP,        // tags and data of the set available
    FILL_SETUP,    // memory read setup
    FILL_ACCESS,   // memory read access, wait states
    FILL_WRITE,    // refill word into victim way
    STORE_SETUP,   // write-through setup
    STORE_ACCESS   // write-through access, wait states
  } ctrl_state_t;

endpackage

/* hdl/dcache_store.sv */
`timescale 1ns/1ns

module dcache_store (
  input logic           CLK,
  dcache_array_if.store arr
);

  dcache_pkg::word_t      data_mem [dcache_pkg::NUM_WAYS][dcache_pkg::NUM_SETS];
  dcache_pkg::tag_entry_t tag_mem  [dcache_pkg::NUM_WAYS][dcache_pkg::NUM_SETS];

  // data ways, read-before-write on the same set
  always_ff @(posedge CLK) begin
    for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
      arr.rd_data[w] <= data_mem[w][arr.rd_index];  // old word on collision
      for (int b = 0; b < dcache_pkg::STRB_W; b++) begin
        if (arr.data_we[w] && arr.byte_en[b]) begin
          data_mem[w][arr.wr_index][8*b +: 8] <= arr.wdata[8*b +: 8];  // lane b only
        end
      end
    end
  end

  // tag ways, whole entry written
  always_ff @(posedge CLK) begin
    for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
      arr.rd_tags[w] <= tag_mem[w][arr.rd_index];
      if (arr.tag_we[w]) begin
        tag_mem[w][arr.wr_index] <= arr.tag_wdata[w];  // valid, age and tag together
      end
    end
  end

  // controller decodes hit/victim way into data_we, never more than one
  assert property (@(posedge CLK) $onehot0(arr.data_we))
    else $error("data write to more than one way: %b", arr.data_we);

endmodule

/* hdl/dcache_top.sv */
`timescale 1ns/1ns

module dcache_top (
  input  logic              CLK,
  input  logic              resetn,
  input  logic              s_psel,
  input  logic              s_penable,
  input  logic              s_pwrite,
  input  dcache_pkg::addr_t s_paddr,
  input  dcache_pkg::word_t s_pwdata,
  input  dcache_pkg::strb_t s_pstrb,
  output dcache_pkg::word_t s_prdata,
  output logic              s_pready,
  output logic              m_psel,
  output logic              m_penable,
  output logic              m_pwrite,
  output dcache_pkg::addr_t m_paddr,
  output dcache_pkg::word_t m_pwdata,
  output dcache_pkg::strb_t m_pstrb,
  input  dcache_pkg::word_t m_prdata,
  input  logic              m_pready
);

  logic                                              hit;
  logic                                              fill_sel;    // refill cycle
  dcache_pkg::way_t                                  hit_way;
  dcache_pkg::way_t                                  victim_way;
  dcache_pkg::tag_t                                  req_tag;
  dcache_pkg::tag_entry_t [dcache_pkg::NUM_WAYS-1:0] new_tags;    // aged entries

  dcache_array_if arr ();  // controller/matcher to storage

  dcache_ctrl u_ctrl (
    .CLK        (CLK),
    .resetn     (resetn),
    .s_psel     (s_psel),
    .s_penable  (s_penable),
    .s_pwrite   (s_pwrite),
    .s_paddr    (s_paddr),
    .s_pwdata   (s_pwdata),
    .s_pstrb    (s_pstrb),
    .s_prdata   (s_prdata),
    .s_pready   (s_pready),
    .m_psel     (m_psel),
    .m_penable  (m_penable),
    .m_pwrite   (m_pwrite),
    .m_paddr    (m_paddr),
    .m_pwdata   (m_pwdata),
    .m_pstrb    (m_pstrb),
    .m_prdata   (m_prdata),
    .m_pready   (m_pready),
    .arr        (arr),
    .hit        (hit),
    .hit_way    (hit_way),
    .victim_way (victim_way),
    .new_tags   (new_tags),
    .req_tag    (req_tag),
    .fill_sel   (fill_sel)
  );

  dcache_match u_match (
    .arr        (arr),
    .req_tag    (req_tag),
    .fill_sel   (fill_sel),
    .hit        (hit),
    .hit_way    (hit_way),
    .victim_way (victim_way),
    .new_tags   (new_tags)
  );

  dcache_store u_store (
    .CLK (CLK),
    .arr (arr)
  );

endmodule

/* run.sh */
#!/bin/sh

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_dcache \
  -f files.f --Mdir obj_dir -o sim_dcache
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_dcache > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Finished with no errors" "$LOG"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi

/* test/apb_mem_model.sv */
`timescale 1ns/1ns

module apb_mem_model (
  input  logic              CLK,
  input  logic              resetn,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  dcache_pkg::addr_t paddr,
  input  dcache_pkg::word_t pwdata,
  input  dcache_pkg::strb_t pstrb,
  output dcache_pkg::word_t prdata,
  output logic              pready,
  output int                wr_count,    // completed writes
  output dcache_pkg::addr_t last_waddr,  // log of the latest write
  output dcache_pkg::word_t last_wdata,
  output dcache_pkg::strb_t last_wstrb
);

  dcache_pkg::word_t mem [dcache_pkg::addr_t];  // only words written so far
  int unsigned       wait_left;                 // wait states still owed

  // unwritten words, pattern over the whole address
  function automatic dcache_pkg::word_t initial_word(input dcache_pkg::addr_t a);
    return {a[19:2], 2'b00, ~a[11:0]};
  endfunction

  function automatic dcache_pkg::word_t read_word(input dcache_pkg::addr_t a);
    return mem.exists(a) ? mem[a] : initial_word(a);
  endfunction

  function automatic void store_word(input dcache_pkg::addr_t a, input dcache_pkg::word_t d,
                                     input dcache_pkg::strb_t s);
    dcache_pkg::word_t w;
    w = read_word(a);
    for (int b = 0; b < dcache_pkg::STRB_W; b++) begin
      if (s[b]) w[8*b +: 8] = d[8*b +: 8];  // strobed lanes only
    end
    mem[a] = w;
  endfunction

  always @(posedge CLK) begin
    if (!resetn) begin
      pready    <= 1'b0;
      prdata    <= '0;
      wait_left <= 0;
      wr_count  <= 0;
    end else begin
      pready <= 1'b0;                                // ready lasts one cycle
      if (psel && !penable) begin
        wait_left <= $urandom_range(3, 0);           // 0..3 extra wait states
      end else if (psel && penable && !pready) begin
        if (wait_left != 0) begin
          wait_left <= wait_left - 1;
        end else begin
          pready <= 1'b1;
          if (pwrite) begin
            store_word(paddr, pwdata, pstrb);
            wr_count   <= wr_count + 1;
            last_waddr <= paddr;
            last_wdata <= pwdata;
            last_wstrb <= pstrb;
          end else begin
            prdata <= read_word(paddr);
          end
        end
      end
    end
  end

endmodule

/* test/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock (
  output logic CLK,
  output logic resetn
);

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;  // 10 ns period
  end

  initial begin
    resetn = 1'b0;
    repeat (10) @(posedge CLK);  // reset held 10 cycles
    @(negedge CLK);
    resetn = 1'b1;               // released away from the active edge
  end

endmodule

/* test/tb_dcache.sv */
`timescale 1ns/1ns

module tb_dcache;

  localparam int WATCHDOG_CYCLES = dcache_pkg::NUM_SETS + 2000 * 20;  // sweep plus worst case
  localparam int RANDOM_OPS      = 600;

  logic              CLK;
  logic              resetn;
  logic              s_psel;
  logic              s_penable;
  logic              s_pwrite;
  dcache_pkg::addr_t s_paddr;
  dcache_pkg::word_t s_pwdata;
  dcache_pkg::strb_t s_pstrb;
  dcache_pkg::word_t s_prdata;
  logic              s_pready;
  logic              m_psel;
  logic              m_penable;
  logic              m_pwrite;
  dcache_pkg::addr_t m_paddr;
  dcache_pkg::word_t m_pwdata;
  dcache_pkg::strb_t m_pstrb;
  dcache_pkg::word_t m_prdata;
  logic              m_pready;
  int                mem_wr_count;
  dcache_pkg::addr_t mem_waddr;
  dcache_pkg::word_t mem_wdata;
  dcache_pkg::strb_t mem_wstrb;

  logic              exp_hit;       // prediction for the read in flight
  dcache_pkg::addr_t exp_maddr;     // word-aligned memory address
  dcache_pkg::word_t exp_rdata;
  dcache_pkg::word_t exp_wdata;
  dcache_pkg::strb_t exp_strb;
  int                exp_wr_count;
  logic              fill_seen;     // memory read done in this transfer
  int                sweep_cycles;  // cycles since reset release

  logic              model_valid [dcache_pkg::NUM_SETS][dcache_pkg::NUM_WAYS];
  dcache_pkg::age_t  model_age   [dcache_pkg::NUM_SETS][dcache_pkg::NUM_WAYS];
  dcache_pkg::tag_t  model_tag   [dcache_pkg::NUM_SETS][dcache_pkg::NUM_WAYS];
  dcache_pkg::word_t shadow      [dcache_pkg::addr_t];  // words written by the cpu

  tb_clock u_clock (.CLK(CLK), .resetn(resetn));

  apb_mem_model u_mem (
    .CLK(CLK), .resetn(resetn), .psel(m_psel), .penable(m_penable), .pwrite(m_pwrite),
    .paddr(m_paddr), .pwdata(m_pwdata), .pstrb(m_pstrb), .prdata(m_prdata),
    .pready(m_pready), .wr_count(mem_wr_count), .last_waddr(mem_waddr),
    .last_wdata(mem_wdata), .last_wstrb(mem_wstrb)
  );

  dcache_top UUT (
    .CLK(CLK), .resetn(resetn), .s_psel(s_psel), .s_penable(s_penable),
    .s_pwrite(s_pwrite), .s_paddr(s_paddr), .s_pwdata(s_pwdata), .s_pstrb(s_pstrb),
    .s_prdata(s_prdata), .s_pready(s_pready), .m_psel(m_psel), .m_penable(m_penable),
    .m_pwrite(m_pwrite), .m_paddr(m_paddr), .m_pwdata(m_pwdata), .m_pstrb(m_pstrb),
    .m_prdata(m_prdata), .m_pready(m_pready)
  );

  task automatic report_failure(input string msg);
    $display("Fail %0t: %s", $time, msg);
    $display("Finished with errors");
    $fatal(1);
  endtask

  // backing memory content as seen by the cpu, write-through keeps it current
  function automatic dcache_pkg::word_t expected_word(input dcache_pkg::addr_t a);
    return shadow.exists(a) ? shadow[a] : {a[19:2], 2'b00, ~a[11:0]};
  endfunction

  function automatic dcache_pkg::word_t merge_lanes(input dcache_pkg::word_t old_w,
                                                    input dcache_pkg::word_t new_w,
                                                    input dcache_pkg::strb_t strb);
    dcache_pkg::word_t w;
    w = old_w;
    for (int b = 0; b < dcache_pkg::STRB_W; b++) begin
      if (strb[b]) w[8*b +: 8] = new_w[8*b +: 8];
    end
    return w;
  endfunction

  function automatic int find_way(input dcache_pkg::addr_t a);
    find_way = -1;  // miss
    for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
      if (model_valid[a[9:2]][w] && model_tag[a[9:2]][w] == a[19:10]) find_way = w;
    end
  endfunction

  function automatic int pick_victim(input dcache_pkg::index_t idx);
    int v;
    v = -1;
    for (int w = dcache_pkg::NUM_WAYS - 1; w >= 0; w--) begin
      if (!model_valid[idx][w]) v = w;  // lowest invalid wins
    end
    if (v < 0) begin
      for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
        if (model_age[idx][w] == 2'd3) v = w;
      end
    end
    return v;
  endfunction

  function automatic void touch_way(input dcache_pkg::index_t idx, input int way);
    dcache_pkg::age_t old_age;
    old_age = model_valid[idx][way] ? model_age[idx][way] : 2'd3;  // invalid counts as oldest
    for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
      if (w != way && model_valid[idx][w] && model_age[idx][w] < old_age) begin
        model_age[idx][w] = model_age[idx][w] + 2'd1;
      end
    end
    model_age[idx][way] = 2'd0;
  endfunction

  function automatic void model_read(input dcache_pkg::addr_t a);
    int way;
    way = find_way(a);
    if (way < 0) begin
      way = pick_victim(a[9:2]);
      touch_way(a[9:2], way);  // ages before the victim turns valid
      model_valid[a[9:2]][way] = 1'b1;
      model_tag[a[9:2]][way]   = a[19:10];
    end else begin
      touch_way(a[9:2], way);
    end
  endfunction

  // no allocation on a write miss
  function automatic void model_write(input dcache_pkg::addr_t a);
    int way;
    way = find_way(a);
    if (way >= 0) touch_way(a[9:2], way);
  endfunction

  task automatic apb_transfer(input dcache_pkg::addr_t addr, input logic write,
                              input dcache_pkg::word_t wdata, input dcache_pkg::strb_t strb);
    s_psel    = 1'b1;  // setup cycle
    s_penable = 1'b0;
    s_pwrite  = write;
    s_paddr   = addr;
    s_pwdata  = wdata;
    s_pstrb   = strb;
    @(negedge CLK);
    s_penable = 1'b1;
    while (!s_pready) @(negedge CLK);  // completes at the next rising edge
    @(negedge CLK);
    s_psel    = 1'b0;
    s_penable = 1'b0;
  endtask

  task automatic cpu_read(input dcache_pkg::addr_t addr);
    exp_hit   = (find_way(addr) >= 0);
    exp_maddr = {addr[19:2], 2'b00};
    exp_rdata = expected_word(exp_maddr);
    apb_transfer(addr, 1'b0, '0, '0);
    model_read(addr);
  endtask

  task automatic cpu_write(input dcache_pkg::addr_t addr, input dcache_pkg::word_t data,
                           input dcache_pkg::strb_t strb);
    exp_maddr    = {addr[19:2], 2'b00};
    exp_wdata    = data;
    exp_strb     = strb;
    exp_wr_count = exp_wr_count + 1;
    apb_transfer(addr, 1'b1, data, strb);
    shadow[exp_maddr] = merge_lanes(expected_word(exp_maddr), data, strb);
    model_write(addr);
  endtask

  always @(posedge CLK) begin
    if (!resetn) begin
      sweep_cycles <= 0;
    end else if (sweep_cycles < dcache_pkg::NUM_SETS) begin
      sweep_cycles <= sweep_cycles + 1;
    end
    if (s_psel && !s_penable) begin
      fill_seen <= 1'b0;                                           // new transfer
    end else if (m_psel && m_penable && m_pready && !m_pwrite) begin
      fill_seen <= 1'b1;
    end
  end

  assert property (@(posedge CLK) disable iff (!resetn)
                   (sweep_cycles < dcache_pkg::NUM_SETS) |-> (!s_pready && !m_psel))
    else report_failure("bus activity during invalidate sweep");

  assert property (@(posedge CLK) disable iff (!resetn)
                   (s_psel && !s_pwrite && m_psel) |->
                   (!exp_hit && !m_pwrite && m_paddr == exp_maddr))
    else report_failure($sformatf("memory read at %h, expected hit %b addr %h",
                                  m_paddr, exp_hit, exp_maddr));

  assert property (@(posedge CLK) disable iff (!resetn)
                   (s_psel && s_penable && s_pready && !s_pwrite) |->
                   (s_prdata == exp_rdata && (exp_hit || fill_seen)))
    else report_failure($sformatf("read %h got %h expected %h, refill seen %b",
                                  s_paddr, s_prdata, exp_rdata, fill_seen));

  assert property (@(posedge CLK) disable iff (!resetn)
                   (s_psel && s_pwrite && m_psel) |->
                   (m_pwrite && m_paddr == exp_maddr && m_pwdata == exp_wdata &&
                    m_pstrb == exp_strb))
    else report_failure($sformatf("memory write %h %h %b expected %h %h %b",
                                  m_paddr, m_pwdata, m_pstrb, exp_maddr, exp_wdata, exp_strb));

  assert property (@(posedge CLK) disable iff (!resetn)
                   (s_psel && s_penable && s_pready && s_pwrite) |->
                   (mem_wr_count == exp_wr_count && mem_waddr == exp_maddr &&
                    mem_wdata == exp_wdata && mem_wstrb == exp_strb))
    else report_failure($sformatf("write %h done with %0d memory writes, expected %0d",
                                  s_paddr, mem_wr_count, exp_wr_count));

  assert property (@(posedge CLK) disable iff (!resetn) (m_psel && !m_pready) |-> !s_pready)
    else report_failure("cpu ready while memory transfer still waiting");

  // memory bus phases, setup then access
  assert property (@(posedge CLK) disable iff (!resetn) m_penable |-> m_psel)
    else report_failure("memory access phase without m_psel");

  assert property (@(posedge CLK) disable iff (!resetn)
                   (m_psel && !m_penable) |=> (m_psel && m_penable))
    else report_failure("memory setup cycle not followed by an access phase");

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    $display("timeout: test did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Finished with errors");
    $fatal(1);
  end

  initial begin
    dcache_pkg::addr_t  a;
    dcache_pkg::tag_t   tg;
    dcache_pkg::index_t idx;
    void'($urandom(32'hb692ca65));
    s_psel       = 1'b0;
    s_penable    = 1'b0;
    s_pwrite     = 1'b0;
    s_paddr      = '0;
    s_pwdata     = '0;
    s_pstrb      = '0;
    exp_hit      = 1'b0;
    exp_maddr    = '0;
    exp_rdata    = '0;
    exp_wdata    = '0;
    exp_strb     = '0;
    exp_wr_count = 0;
    for (int s = 0; s < dcache_pkg::NUM_SETS; s++) begin
      for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
        model_valid[s][w] = 1'b0;  // cache starts empty after the sweep
        model_age[s][w]   = 2'd3;
        model_tag[s][w]   = '0;
      end
    end
    @(negedge CLK);
    while (sweep_cycles < dcache_pkg::NUM_SETS) @(negedge CLK);
    repeat (3) @(negedge CLK);

    cpu_read(20'h12347);  // cold miss, unaligned byte address
    cpu_read(20'h12344);  // same word hits
    cpu_read(20'h2a0f0);
    cpu_read(20'h12346);

    for (int t = 1; t <= 5; t++) cpu_read({dcache_pkg::tag_t'(t), 8'h5a, 2'b00});
    cpu_read({dcache_pkg::tag_t'(1), 8'h5a, 2'b00});  // evicted by the age rule
    for (int t = 3; t <= 5; t++) cpu_read({dcache_pkg::tag_t'(t), 8'h5a, 2'b00});

    cpu_write({dcache_pkg::tag_t'(5), 8'h5a, 2'b00}, 32'hdead_beef, 4'b0101);  // write hit
    cpu_read({dcache_pkg::tag_t'(5), 8'h5a, 2'b00});
    cpu_write(20'h7f1c8, 32'h1234_5678, 4'b1100);  // write miss, no allocation
    cpu_read(20'h7f1c8);

    // small pool of sets and tags, plenty of conflicts
    for (int i = 0; i < RANDOM_OPS; i++) begin
      tg  = dcache_pkg::tag_t'($urandom_range(7, 0));
      idx = dcache_pkg::index_t'(8'h30 + $urandom_range(3, 0));
      a   = {tg, idx, 2'($urandom_range(3, 0))};
      if ($urandom_range(9, 0) < 3) begin
        cpu_write(a, $urandom(), dcache_pkg::strb_t'($urandom_range(15, 1)));
      end else begin
        cpu_read(a);
      end
    end

    repeat (5) @(negedge CLK);
    $display("Finished with no errors");
    $finish;
  end

endmodule
